//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fml_tb -f sim.f
./obj_dir/Vfml_tb | tee sim.log

if grep -q "Checks failed" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

//--- sim.f
source/fml_pkg.sv
source/fml_arbiter.sv
source/fml_burst_ram.sv
source/fml_subsystem.sv
tests/fml_tb.sv

//--- source/fml_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fml_arbiter (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  fml_pkg::fml_req_t             m_req [fml_pkg::fml_ports],
	input  fml_pkg::fml_wbeat_t           m_wbeat [fml_pkg::fml_ports],
	output logic [fml_pkg::fml_ports-1:0] m_ack,
	output fml_pkg::fml_req_t             s_req,
	output fml_pkg::fml_wbeat_t           s_wbeat,
	input  logic                          s_ack
);
	import fml_pkg::*;

	fml_port_t            grant;
	fml_port_t            next_grant;
	fml_port_t            order [fml_ports-1]; // Fallback order of the current owner
	logic [fml_ports-1:0] stb;
	logic                 release_grant;

	fml_port_t            wsel; // Owner of the write beats
	logic [1:0]           burst_counter;
	logic                 write_start;

	//////////////////////////////////////////////////
	// Address side
	//////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < fml_ports; i++) begin
			stb[i] = m_req[i].stb;
		end
	end

	// Port 0 heads every list except its own
	always_comb begin
		case (grant)
			port0:   order = '{port1, port2, port3, port4, port5};
			port1:   order = '{port0, port3, port4, port5, port2};
			port2:   order = '{port0, port3, port4, port5, port1};
			port3:   order = '{port0, port4, port5, port1, port2};
			port4:   order = '{port0, port5, port1, port2, port3};
			default: order = '{port0, port1, port2, port3, port4}; // port5
		endcase
	end

	assign release_grant = !stb[grant] || s_ack; // Owner idle or just served

	always_comb begin
		next_grant = grant; // Nobody asking keeps the current owner
		if (release_grant) begin
			// Scan from the back so the earliest requester in the list wins
			for (int i = fml_ports - 2; i >= 0; i--) begin
				if (stb[order[i]])
					next_grant = order[i];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			grant <= port0;
		else
			grant <= next_grant;
	end

	always_comb begin
		m_ack        = '0;
		m_ack[grant] = s_ack; // Only the owner sees the acknowledge
	end

	assign s_req = m_req[grant];

	//////////////////////////////////////////////////
	// Write data side
	//////////////////////////////////////////////////

	// Beats 1 to 3 trail the acknowledge, so the selector must lag the grant
	assign write_start = s_req.we && s_ack;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wsel          <= port0;
			burst_counter <= '0;
		end else begin
			if (write_start)
				burst_counter <= 2'(fml_burst_len - 2);
			else if (burst_counter != '0)
				burst_counter <= burst_counter - 2'd1;

			// Catch up with the grant once the last beat is on the bus
			if (!write_start && burst_counter == '0)
				wsel <= next_grant;
		end
	end

	assign s_wbeat = m_wbeat[wsel];

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_ack_onehot: assert property (
		@(posedge sys_clk) disable iff (sys_rst) $onehot0(m_ack)
	) else $error("Acknowledge routed to more than one port");

	a_grant_range: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		grant inside {port0, port1, port2, port3, port4, port5}
	) else $error("Grant register holds an invalid port");

	// Beats 1 to 3 must come from the same port as beat 0
	a_wsel_frozen: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		(burst_counter != '0) |=> $stable(wsel)
	) else $error("Write selector moved during a write burst");

	// The selector has caught up by the time the next write is acknowledged
	a_wsel_aligned: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		write_start |-> (wsel == grant)
	) else $error("Write beat 0 taken from a port other than the owner");

endmodule

`default_nettype wire

//--- source/fml_burst_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fml_burst_ram (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  fml_pkg::fml_req_t   req,
	input  fml_pkg::fml_wbeat_t wbeat,
	output logic                ack,
	output logic [63:0]         rdata
);
	import fml_pkg::*;

	localparam int beat_bits = $clog2(fml_burst_len);

	ram_state_t                state;
	logic [ram_burst_bits-1:0] burst_adr; // Burst number taken at acceptance
	logic                      write_q;
	logic [beat_bits-1:0]      beat;      // Beat currently on the bus

	logic [63:0]               mem [2**(ram_burst_bits + beat_bits)];

	logic                      mem_write;
	logic                      fetch;
	logic [beat_bits-1:0]      fetch_beat;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= ram_idle;
			write_q  <= 1'b0;
			beat     <= '0;
		end else begin
			case (state)
				ram_idle: if (req.stb) begin
					write_q <= req.we;
					beat    <= '0;
					state   <= ram_ack;
				end
				ram_ack: if (write_q) begin
					beat  <= beat + beat_bits'(1); // Beat 0 goes in with the ack
					state <= ram_write;
				end else begin
					state <= ram_read_wait;
				end
				ram_write: begin
					beat <= beat + beat_bits'(1);
					if (beat == beat_bits'(fml_burst_len - 1))
						state <= ram_idle;
				end
				ram_read_wait: state <= ram_read;
				ram_read: begin
					beat <= beat + beat_bits'(1);
					if (beat == beat_bits'(fml_burst_len - 1))
						state <= ram_idle;
				end
				default: state <= ram_idle;
			endcase
		end
	end

	// Burst address for the whole transfer
	always_ff @(posedge sys_clk) begin
		if (state == ram_idle && req.stb)
			burst_adr <= req.adr[fml_burst_lsb +: ram_burst_bits];
	end

	assign ack = (state == ram_ack);

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	assign mem_write = (state == ram_ack && write_q) || state == ram_write;

	always_ff @(posedge sys_clk) begin
		if (mem_write) begin
			for (int i = 0; i < 8; i++) begin
				if (wbeat.sel[i])
					mem[{burst_adr, beat}][i*8 +: 8] <= wbeat.data[i*8 +: 8];
			end
		end
	end

	// Each beat is fetched one cycle ahead so it is on the bus for its whole cycle
	assign fetch = state == ram_read_wait
		|| (state == ram_read && beat != beat_bits'(fml_burst_len - 1));
	assign fetch_beat = (state == ram_read) ? beat + beat_bits'(1) : '0;

	always_ff @(posedge sys_clk) begin
		if (fetch)
			rdata <= mem[{burst_adr, fetch_beat}];
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_ack_single: assert property (
		@(posedge sys_clk) disable iff (sys_rst) ack |=> !ack
	) else $error("Acknowledge held for more than one cycle");

	a_adr_range: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		(state == ram_idle && req.stb) |-> (req.adr[fml_depth-1:ram_adr_bits] == '0)
	) else $error("Request address outside the modeled bursts");

endmodule

`default_nettype wire

//--- source/fml_pkg.sv
`default_nettype none

package fml_pkg;

	//////////////////////////////////////////////////
	// Bus geometry
	//////////////////////////////////////////////////

	localparam int fml_depth     = 26; // Byte address width
	localparam int fml_ports     = 6;
	localparam int fml_burst_len = 4;  // 64-bit beats per burst

	// Byte address bit where the burst number starts (8 bytes per beat, 4 beats)
	localparam int fml_burst_lsb = 3 + $clog2(fml_burst_len);

	localparam int ram_burst_bits   = 6; // 64 bursts of 4 words in the model
	localparam int ram_adr_bits     = fml_burst_lsb + ram_burst_bits;
	localparam int ram_read_latency = 2; // Ack cycle to first read beat

	//////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [fml_depth-1:0] adr;
		logic                 stb;
		logic                 we;
	} fml_req_t;

	typedef struct packed {
		logic [7:0]  sel;  // One enable per byte lane
		logic [63:0] data;
	} fml_wbeat_t;

	typedef enum logic [2:0] {
		port0, port1, port2, port3, port4, port5
	} fml_port_t;

	typedef enum logic [2:0] {
		ram_idle,
		ram_ack,
		ram_write,
		ram_read_wait,
		ram_read
	} ram_state_t;

endpackage

`default_nettype wire

//--- source/fml_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module fml_subsystem (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  fml_pkg::fml_req_t             m_req [fml_pkg::fml_ports],
	input  fml_pkg::fml_wbeat_t           m_wbeat [fml_pkg::fml_ports],
	output logic [fml_pkg::fml_ports-1:0] m_ack,
	output logic [63:0]                   m_rdata
);
	import fml_pkg::*;

	fml_req_t   s_req;   // Granted request toward the RAM
	fml_wbeat_t s_wbeat;
	logic       s_ack;

	fml_arbiter arbiter (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.m_req   (m_req),
		.m_wbeat (m_wbeat),
		.m_ack   (m_ack),
		.s_req   (s_req),
		.s_wbeat (s_wbeat),
		.s_ack   (s_ack)
	);

	// Read data skips the arbiter and reaches every port at once
	fml_burst_ram ram (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.req     (s_req),
		.wbeat   (s_wbeat),
		.ack     (s_ack),
		.rdata   (m_rdata)
	);

endmodule

`default_nettype wire

//--- tests/fml_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fml_tb;
	import fml_pkg::*;

	localparam int max_cycles   = 20000; // About 300 bursts of up to 7 cycles, plus contention
	localparam int random_count = 40;    // Bursts per port in the random test

	logic                 sys_clk;
	logic                 sys_rst;
	fml_req_t             m_req [fml_ports];
	fml_wbeat_t           m_wbeat [fml_ports];
	logic [fml_ports-1:0] m_ack;
	logic [63:0]          m_rdata;

	logic [63:0]          shadow [2**(ram_burst_bits + 2)]; // Expected memory contents
	string                test_name = "reset";
	int                   seed = 94;
	int                   error_count = 0;
	int                   req_count = 0;
	int                   ack_count = 0;
	int                   cycles = 0;
	fml_port_t            model_grant = port0;
	int                   rd_age = -1; // Cycles since a read acknowledge, -1 when idle
	logic [fml_depth-1:0] rd_adr;
	int                   wr_left = 0; // Write beats still to capture
	int                   wr_port;
	logic [fml_depth-1:0] wr_adr;

	fml_subsystem dut (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.m_req   (m_req),
		.m_wbeat (m_wbeat),
		.m_ack   (m_ack),
		.m_rdata (m_rdata)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic fml_port_t ref_next_grant(fml_port_t cur, logic [fml_ports-1:0] stb);
		int        order [5];
		fml_port_t result;
		logic      found;
		case (cur)
			port0:   order = '{1, 2, 3, 4, 5};
			port1:   order = '{0, 3, 4, 5, 2};
			port2:   order = '{0, 3, 4, 5, 1};
			port3:   order = '{0, 4, 5, 1, 2};
			port4:   order = '{0, 5, 1, 2, 3};
			default: order = '{0, 1, 2, 3, 4};
		endcase
		result = cur; // Nobody asking keeps the owner
		found  = 1'b0;
		foreach (order[i]) begin
			if (!found && stb[order[i]]) begin
				result = fml_port_t'(3'(order[i]));
				found  = 1'b1;
			end
		end
		return result;
	endfunction

	function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [63:0] data,
		logic [7:0] sel);
		logic [63:0] result;
		result = old;
		for (int i = 0; i < 8; i++) begin
			if (sel[i])
				result[i*8 +: 8] = data[i*8 +: 8];
		end
		return result;
	endfunction

	function automatic logic [7:0] shadow_index(logic [fml_depth-1:0] adr, int beat);
		return {adr[fml_burst_lsb +: ram_burst_bits], beat[1:0]};
	endfunction

	function automatic logic [63:0] ref_read_beat(logic [fml_depth-1:0] adr, int beat);
		return shadow[shadow_index(adr, beat)];
	endfunction

	function automatic logic [fml_depth-1:0] burst_adr(int n);
		return fml_depth'(n) << fml_burst_lsb;
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		error_count++;
		$display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
	endtask

	//////////////////////////////////////////////////
	// Client ports
	//////////////////////////////////////////////////

	task automatic issue_burst(input int p, input logic we, input logic [fml_depth-1:0] adr,
		input logic [255:0] data, input logic [31:0] sel, output logic [255:0] rd);
		rd = '0;
		@(posedge sys_clk);
		#1;
		m_req[p]   = '{adr: adr, stb: 1'b1, we: we};
		m_wbeat[p] = '{sel: sel[7:0], data: data[63:0]}; // Beat 0 rides with the acknowledge
		req_count++;
		@(negedge sys_clk);
		while (!m_ack[p])
			@(negedge sys_clk);
		@(posedge sys_clk);
		#1;
		m_req[p].stb = 1'b0;
		if (we) begin
			for (int b = 1; b < fml_burst_len; b++) begin
				if (b > 1) begin
					@(posedge sys_clk);
					#1;
				end
				m_wbeat[p] = '{sel: sel[b*8 +: 8], data: data[b*64 +: 64]};
			end
		end else begin
			@(negedge sys_clk); // Cycle A+1 carries no data
			for (int b = 0; b < fml_burst_len; b++) begin
				@(negedge sys_clk);
				rd[b*64 +: 64] = m_rdata;
			end
		end
	endtask

	task automatic random_port(input int p);
		logic [255:0] data;
		logic [255:0] rd;
		logic [31:0]  sel;
		logic         we;
		int           burst;
		for (int n = 0; n < random_count; n++) begin
			we    = 1'($random(seed));
			burst = int'($unsigned($random(seed)) % 64);
			sel   = $random(seed);
			for (int i = 0; i < 8; i++)
				data[i*32 +: 32] = $random(seed);
			issue_burst(p, we, burst_adr(burst), data, sel, rd);
		end
	endtask

	//////////////////////////////////////////////////
	// Compare process
	//////////////////////////////////////////////////

	always @(negedge sys_clk) begin
		logic [fml_ports-1:0] stb_now;
		logic [63:0]          expected;
		int                   p;
		cycles++;
		for (int i = 0; i < fml_ports; i++)
			stb_now[i] = m_req[i].stb;
		p = 0;
		for (int i = 0; i < fml_ports; i++) begin
			if (m_ack[i])
				p = i;
		end
		if (sys_rst) begin
			if (m_ack != '0) begin
				error_count++;
				$display("Acknowledge raised on ports %b during reset", m_ack);
			end
			model_grant = port0;
			rd_age      = -1;
			wr_left     = 0;
		end else begin
			if (rd_age >= 0) begin
				rd_age++;
				if (rd_age >= ram_read_latency) begin
					expected = ref_read_beat(rd_adr, rd_age - ram_read_latency);
					if (m_rdata !== expected)
						report_mismatch($sformatf("read beat %0d", rd_age - ram_read_latency),
							expected, m_rdata);
					if (rd_age == ram_read_latency + fml_burst_len - 1)
						rd_age = -1;
				end
			end
			if (m_ack != '0) begin
				ack_count++;
				if (!$onehot(m_ack)) begin
					error_count++;
					$display("Acknowledge raised on several ports at once: %b", m_ack);
				end else if (!stb_now[p]) begin
					error_count++;
					$display("Port %0d got an acknowledge without a request", p);
				end else begin
					if (p != model_grant) begin
						error_count++;
						$display("Error %s acknowledge order: expected port %0d, actual port %0d",
							test_name, model_grant, p);
					end
					if (m_req[p].we) begin
						wr_port = p;
						wr_adr  = m_req[p].adr;
						wr_left = fml_burst_len;
					end else begin
						rd_adr = m_req[p].adr;
						rd_age = 0;
					end
				end
			end
			if (wr_left > 0) begin // One write beat per cycle from the owner
				shadow[shadow_index(wr_adr, fml_burst_len - wr_left)] = merge_bytes(
					ref_read_beat(wr_adr, fml_burst_len - wr_left),
					m_wbeat[wr_port].data, m_wbeat[wr_port].sel);
				wr_left--;
			end
			if (!stb_now[model_grant] || m_ack != '0)
				model_grant = ref_next_grant(model_grant, stb_now);
		end
	end

	initial begin
		while (cycles < max_cycles)
			@(posedge sys_clk);
		$display("Timeout after %0d cycles with a request still waiting", cycles);
		$display("Checks failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [255:0] data;
		logic [255:0] rd;
		logic [255:0] scratch;
		logic [255:0] pattern;
		logic [63:0]  expected;
		int           w;
		sys_rst = 1'b1;
		for (int i = 0; i < fml_ports; i++) begin
			m_req[i]   = '0;
			m_wbeat[i] = '0;
		end
		repeat (8) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		@(negedge sys_clk);
		if (m_ack != '0) begin
			error_count++;
			$display("Acknowledge raised on ports %b right after reset", m_ack);
		end
		issue_burst(5, 1'b1, burst_adr(1), {4{64'h5555_0000_aaaa_ffff}}, '1, scratch);

		test_name = "single_port";
		data = {64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210,
			64'h1111_2222_3333_4444, 64'hdead_beef_cafe_f00d};
		issue_burst(3, 1'b1, burst_adr(7), data, '1, scratch);
		issue_burst(3, 1'b0, burst_adr(7), '0, '0, rd);
		for (int b = 0; b < fml_burst_len; b++) begin
			if (rd[b*64 +: 64] !== data[b*64 +: 64])
				report_mismatch($sformatf("beat %0d", b), data[b*64 +: 64], rd[b*64 +: 64]);
		end

		test_name = "byte_enables";
		issue_burst(3, 1'b1, burst_adr(7), ~data, 32'h0f3c_a581, scratch);
		issue_burst(3, 1'b0, burst_adr(7), '0, '0, rd);
		for (int b = 0; b < fml_burst_len; b++) begin
			expected = merge_bytes(data[b*64 +: 64], ~data[b*64 +: 64], 8'(32'h0f3c_a581 >> (b*8)));
			if (rd[b*64 +: 64] !== expected)
				report_mismatch($sformatf("beat %0d", b), expected, rd[b*64 +: 64]);
		end

		test_name = "priority";
		fork
			issue_burst(0, 1'b1, burst_adr(20), data, '1, scratch);
			issue_burst(1, 1'b1, burst_adr(21), ~data, '1, scratch);
			issue_burst(2, 1'b1, burst_adr(22), data, 32'h00ff_ff00, scratch);
			issue_burst(3, 1'b1, burst_adr(23), data, '1, scratch);
			issue_burst(4, 1'b0, burst_adr(20), '0, '0, scratch);
			issue_burst(5, 1'b0, burst_adr(21), '0, '0, scratch);
		join
		fork
			issue_burst(2, 1'b0, burst_adr(20), '0, '0, scratch);
			issue_burst(3, 1'b0, burst_adr(21), '0, '0, scratch);
			issue_burst(4, 1'b1, burst_adr(24), data, '1, scratch);
			issue_burst(5, 1'b0, burst_adr(22), '0, '0, scratch);
			begin // Port 0 arrives while the others queue
				repeat (3) @(posedge sys_clk);
				issue_burst(0, 1'b0, burst_adr(23), '0, '0, scratch);
			end
		join

		test_name = "write_handover";
		issue_burst(0, 1'b0, burst_adr(24), '0, '0, scratch); // Parks the grant on port 0
		data = {64'h2222_aaaa_0000_0003, 64'h2222_aaaa_0000_0002,
			64'h2222_aaaa_0000_0001, 64'h2222_aaaa_0000_0000};
		fork
			issue_burst(2, 1'b1, burst_adr(30), data, '1, scratch);
			begin
				@(posedge sys_clk);
				issue_burst(4, 1'b0, burst_adr(30), '0, '0, rd);
			end
		join
		for (int b = 0; b < fml_burst_len; b++) begin
			if (rd[b*64 +: 64] !== data[b*64 +: 64])
				report_mismatch($sformatf("beat %0d", b), data[b*64 +: 64], rd[b*64 +: 64]);
		end

		test_name = "random";
		for (int n = 0; n < 2**ram_burst_bits; n++) begin
			for (int b = 0; b < fml_burst_len; b++) begin
				w = n * fml_burst_len + b;
				pattern[b*64 +: 64] = {32'h5a5a_0000 ^ 32'(w), ~32'(w)};
			end
			issue_burst(n % fml_ports, 1'b1, burst_adr(n), pattern, '1, scratch);
		end
		fork
			random_port(0);
			random_port(1);
			random_port(2);
			random_port(3);
			random_port(4);
			random_port(5);
		join

		repeat (8) @(posedge sys_clk);
		if (ack_count != req_count) begin
			error_count++;
			$display("Saw %0d acknowledges for %0d requests", ack_count, req_count);
		end
		$display("Summary: %0d errors, %0d requests, %0d acknowledges",
			error_count, req_count, ack_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
